/* Bender.yml */
package:
  name: cpu

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_pkg.sv
      - design/alu.sv
      - design/program_mem.sv
      - design/io_bus_bridge.sv
      - design/instr_decoder.sv
      - design/cpu_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/clock_gen.sv
      - testbench/cpu_tb.sv

/* compile.f */
+incdir+design
design/cpu_pkg.sv
design/alu.sv
design/program_mem.sv
design/io_bus_bridge.sv
design/instr_decoder.sv
design/cpu_top.sv
testbench/clock_gen.sv
testbench/cpu_tb.sv

/* design/alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module alu
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    alu_en,
    input  alu_op_t alu_op_id,
    input  word_t   alu_op1,
    input  word_t   alu_op2,
    input  word_t   alu_op3,
    output word_t   alu_out,
    output word_t   alu_out2,
    output logic    c,
    output logic    z
);

    logic [2*`DATA_WIDTH-1:0] product;
    word_t res, res2;
    logic res_c, write_out;

    // multiply-accumulate, op3 added into the low word
    assign product = alu_op1 * alu_op2 + {{`DATA_WIDTH{1'b0}}, alu_op3};

    always_comb begin
        res = '0;
        res2 = '0;
        res_c = 1'b0;
        write_out = 1'b1;
        case (alu_op_id)
            `ALU_OP_ADD: {res_c, res} = {1'b0, alu_op1} + {1'b0, alu_op2};
            `ALU_OP_SUB: {res_c, res} = {1'b0, alu_op1} - {1'b0, alu_op2};
            `ALU_OP_AND: res = alu_op1 & alu_op2;
            `ALU_OP_OR: res = alu_op1 | alu_op2;
            `ALU_OP_XOR: res = alu_op1 ^ alu_op2;
            // carry takes the last bit shifted out
            `ALU_OP_SHL: {res_c, res} = {1'b0, alu_op1} << alu_op2[3:0];
            `ALU_OP_SHR: {res, res_c} = {alu_op1, 1'b0} >> alu_op2[3:0];
            `ALU_OP_MUL: {res2, res} = product;
            `ALU_OP_DIV: begin
                if (alu_op2 == '0) begin
                    res = '1;
                    res2 = '1;
                    res_c = 1'b1;
                end else begin
                    res = alu_op1 / alu_op2;
                    res2 = alu_op1 % alu_op2;
                end
            end
            `ALU_OP_CMP: begin
                {res_c, res} = {1'b0, alu_op1} - {1'b0, alu_op2};
                write_out = 1'b0;
            end
            `ALU_OP_TEST: begin
                res = alu_op1 & alu_op2;
                write_out = 1'b0;
            end
            default: write_out = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            c <= 1'b0;
            z <= 1'b0;
        end else if (alu_en) begin
            c <= res_c;
            z <= res == '0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_en && write_out) begin
            alu_out <= res;
            alu_out2 <= res2;
        end
    end

    a_zero_flag: assert property (@(posedge clk) disable iff (!reset)
        alu_en && write_out |=> z == (alu_out == '0));

endmodule

`default_nettype wire

/* design/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define DATA_WIDTH      16
`define INSTR_WIDTH     32
`define REG_ID_WIDTH    8
`define ALU_OPID_WIDTH  5
`define PROG_ADDR_WIDTH 8

// io map, words below IO_LOCAL_WORDS live in local RAM
`define IO_LOCAL_WORDS  64
`define IO_EXT_BASE     16'h8000
`define INT_VECTOR      16'd1

// opcode groups, instruction bits [7:5]
`define OP_JMP          3'd0
`define OP_CALL         3'd1
`define OP_SPECIAL      3'd2
`define OP_ALU_RR       3'd3
`define OP_ALU_IR       3'd4
`define OP_ALU_IOR      3'd5
`define OP_ALU_RIO      3'd6
`define OP_IO           3'd7

// alu op ids, instruction bits [4:0]
`define ALU_OP_ADD      5'd0
`define ALU_OP_SUB      5'd1
`define ALU_OP_AND      5'd2
`define ALU_OP_OR       5'd3
`define ALU_OP_XOR      5'd4
`define ALU_OP_SHL      5'd5
`define ALU_OP_SHR      5'd6
`define ALU_OP_MUL      5'd7
`define ALU_OP_DIV      5'd8
`define ALU_OP_CMP      5'd9
`define ALU_OP_TEST     5'd10

`endif

/* design/cpu_pkg.sv */
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [`INSTR_WIDTH-1:0] instr_t;
    typedef logic [`REG_ID_WIDTH-1:0] reg_id_t;
    typedef logic [`ALU_OPID_WIDTH-1:0] alu_op_t;

    // decoder sequence per instruction
    typedef enum logic [2:0] {
        fetch,
        decode,
        operate,
        writeback,
        io_finish
    } stage_t;

endpackage

`default_nettype wire

/* design/cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        interrupt,
    input  logic                        load_en,
    input  logic [`PROG_ADDR_WIDTH-1:0] load_addr,
    input  instr_t                      load_data,
    output logic                        dev_rd,
    output logic                        dev_wr,
    output word_t                       dev_address,
    output word_t                       dev_wdata,
    input  word_t                       dev_rdata,
    output logic                        hlt,
    output logic                        error
);

    word_t address, alu_op1, alu_op2, alu_op3, alu_out, alu_out2;
    word_t io_address, io_data_out, io_data_in;
    instr_t instruction;
    alu_op_t alu_op_id;
    logic alu_en, c, z, io_rd, io_wr;

    instr_decoder u_instr_decoder (
        .clk        (clk),
        .reset      (reset),
        .interrupt  (interrupt),
        .instruction(instruction),
        .c          (c),
        .z          (z),
        .alu_out    (alu_out),
        .alu_out2   (alu_out2),
        .io_data_in (io_data_in),
        .address    (address),
        .alu_op_id  (alu_op_id),
        .alu_op1    (alu_op1),
        .alu_op2    (alu_op2),
        .alu_op3    (alu_op3),
        .alu_en     (alu_en),
        .io_rd      (io_rd),
        .io_wr      (io_wr),
        .io_address (io_address),
        .io_data_out(io_data_out),
        .hlt        (hlt),
        .error      (error)
    );

    alu u_alu (
        .clk      (clk),
        .reset    (reset),
        .alu_en   (alu_en),
        .alu_op_id(alu_op_id),
        .alu_op1  (alu_op1),
        .alu_op2  (alu_op2),
        .alu_op3  (alu_op3),
        .alu_out  (alu_out),
        .alu_out2 (alu_out2),
        .c        (c),
        .z        (z)
    );

    program_mem u_program_mem (
        .clk        (clk),
        .address    (address[`PROG_ADDR_WIDTH-1:0]),
        .instruction(instruction),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    io_bus_bridge u_io_bus_bridge (
        .clk        (clk),
        .reset      (reset),
        .io_rd      (io_rd),
        .io_wr      (io_wr),
        .io_address (io_address),
        .io_data_out(io_data_out),
        .io_data_in (io_data_in),
        .dev_rd     (dev_rd),
        .dev_wr     (dev_wr),
        .dev_address(dev_address),
        .dev_wdata  (dev_wdata),
        .dev_rdata  (dev_rdata)
    );

endmodule

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module instr_decoder
    import cpu_pkg::*;
#(
    parameter int STACK_BITS = 4
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    interrupt,
    input  instr_t  instruction,
    input  logic    c,
    input  logic    z,
    input  word_t   alu_out,
    input  word_t   alu_out2,
    input  word_t   io_data_in,
    output word_t   address,
    output alu_op_t alu_op_id,
    output word_t   alu_op1,
    output word_t   alu_op2,
    output word_t   alu_op3,
    output logic    alu_en,
    output logic    io_rd,
    output logic    io_wr,
    output word_t   io_address,
    output word_t   io_data_out,
    output logic    hlt,
    output logic    error
);

    localparam alu_op_t SUB_MOVF = 5'h1b;
    localparam alu_op_t SUB_MOVI = 5'h1d;
    localparam alu_op_t SUB_MOVR = 5'h1e;
    localparam alu_op_t SUB_HLT  = 5'h1f;

    word_t regs [0:(1 << `REG_ID_WIDTH)-1];
    word_t stack [0:(1 << STACK_BITS)-1];
    logic [STACK_BITS-1:0] sp;
    stage_t stage;
    instr_t cur;
    logic in_interrupt;

    // fields of the word at address
    logic [2:0] op;
    alu_op_t sub;
    reg_id_t rd, rs, rt;
    word_t imm, target, reg_off;
    logic taken, is_ret, decode_ok, int_take;

    // fields of the latched instruction
    logic [2:0] cur_op;
    alu_op_t cur_sub;
    reg_id_t cur_rd, cur_rs;
    logic cur_no_wb, cur_wide;

    function automatic logic cond_met(input logic [3:0] cond, input logic cf, input logic zf);
        case (cond)
            4'd0: return 1'b1;
            4'd1, 4'd2: return cf == cond[0];
            4'd3, 4'd4: return zf == cond[0];
            4'd5: return !zf && !cf;
            4'd6: return zf || cf;
            default: return 1'b0;
        endcase
    endfunction

    assign op = instruction[7:5];
    assign sub = instruction[`ALU_OPID_WIDTH-1:0];
    assign rd = instruction[15:8];
    assign rs = instruction[23:16];
    assign rt = instruction[31:24];
    assign imm = instruction[`INSTR_WIDTH-1 -: `DATA_WIDTH];
    assign taken = cond_met(instruction[3:0], c, z);
    // bit 4 selects register-relative target
    assign target = instruction[4] ? regs[rd] + imm : imm;
    assign reg_off = regs[rs] + word_t'(rt);
    assign is_ret = !sub[3] && sub[2:0] != 3'd7;
    assign int_take = interrupt && !in_interrupt;

    always_comb begin
        case (op)
            `OP_JMP, `OP_CALL: decode_ok = instruction[3:0] < 4'd7;
            `OP_SPECIAL: decode_ok = is_ret || sub >= SUB_MOVF;
            `OP_IO: decode_ok = sub < 5'd2;
            default: decode_ok = sub <= `ALU_OP_TEST;
        endcase
    end

    assign cur_op = cur[7:5];
    assign cur_sub = cur[`ALU_OPID_WIDTH-1:0];
    assign cur_rd = cur[15:8];
    assign cur_rs = cur[23:16];
    assign cur_no_wb = cur_sub == `ALU_OP_CMP || cur_sub == `ALU_OP_TEST;
    assign cur_wide = cur_sub == `ALU_OP_MUL || cur_sub == `ALU_OP_DIV;
    assign alu_op_id = cur_sub;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            stage <= fetch;
            address <= '0;
            sp <= '0;
            in_interrupt <= 1'b0;
            io_rd <= 1'b1;
            io_wr <= 1'b1;
            alu_en <= 1'b0;
            hlt <= 1'b0;
            error <= 1'b0;
        end else if (!hlt) begin
            alu_en <= 1'b0;
            case (stage)
                fetch: begin
                    if (int_take) begin
                        in_interrupt <= 1'b1;
                        sp <= sp - 1'b1;
                        address <= `INT_VECTOR;
                    end
                    stage <= decode;
                end
                decode: begin
                    stage <= operate;
                    if (!decode_ok) begin
                        hlt <= 1'b1;
                        error <= 1'b1;
                    end else begin
                        case (op)
                            `OP_JMP, `OP_CALL: begin
                                stage <= fetch;
                                address <= taken ? target : address + 1'b1;
                                if (op == `OP_CALL && taken)
                                    sp <= sp - 1'b1;
                            end
                            `OP_SPECIAL: begin
                                stage <= fetch;
                                if (sub == SUB_HLT) begin
                                    hlt <= 1'b1;
                                end else if (is_ret && taken) begin
                                    address <= stack[sp];
                                    sp <= sp + 1'b1;
                                    // reti
                                    if (sub[4])
                                        in_interrupt <= 1'b0;
                                end else begin
                                    address <= address + 1'b1;
                                end
                            end
                            `OP_ALU_IOR: begin
                                io_rd <= 1'b0;
                                address <= address + 1'b1;
                            end
                            `OP_IO: begin
                                if (sub[0])
                                    io_wr <= 1'b0;
                                else
                                    io_rd <= 1'b0;
                                address <= address + 1'b1;
                            end
                            default: begin
                                alu_en <= 1'b1;
                                address <= address + 1'b1;
                            end
                        endcase
                    end
                end
                operate: begin
                    io_rd <= 1'b1;
                    io_wr <= 1'b1;
                    case (cur_op)
                        `OP_IO: stage <= fetch;
                        `OP_ALU_RIO: stage <= writeback;
                        `OP_ALU_IOR: begin
                            alu_en <= 1'b1;
                            stage <= writeback;
                        end
                        default: stage <= cur_no_wb ? fetch : writeback;
                    endcase
                end
                writeback: begin
                    if (cur_op == `OP_ALU_RIO) begin
                        io_wr <= 1'b0;
                        stage <= io_finish;
                    end else if (cur_op == `OP_ALU_IOR && !cur_no_wb) begin
                        stage <= io_finish;
                    end else begin
                        stage <= fetch;
                    end
                end
                default: begin
                    io_wr <= 1'b1;
                    stage <= fetch;
                end
            endcase
        end
    end

    // register file, return stack and operand latches
    always_ff @(posedge clk) begin
        if (!hlt) begin
            case (stage)
                fetch: begin
                    if (int_take)
                        stack[sp - 1'b1] <= address;
                end
                decode: begin
                    cur <= instruction;
                    case (op)
                        `OP_CALL: begin
                            if (taken)
                                stack[sp - 1'b1] <= address + 1'b1;
                        end
                        `OP_SPECIAL: begin
                            if (sub == SUB_MOVF)
                                regs[rd] <= {{(`DATA_WIDTH-2){1'b0}}, c, z};
                            else if (sub == SUB_MOVI)
                                regs[rd] <= imm;
                            else if (sub == SUB_MOVR)
                                regs[rd] <= reg_off;
                        end
                        `OP_ALU_RR: begin
                            alu_op1 <= regs[rs];
                            alu_op2 <= regs[rt];
                            alu_op3 <= regs[rd];
                        end
                        `OP_ALU_IR: begin
                            alu_op1 <= imm;
                            alu_op2 <= regs[rd];
                            alu_op3 <= '0;
                        end
                        `OP_ALU_IOR: begin
                            io_address <= regs[rt];
                            alu_op1 <= regs[rs];
                            alu_op3 <= '0;
                        end
                        `OP_ALU_RIO: begin
                            io_address <= regs[rt];
                            alu_op1 <= regs[rs];
                            alu_op2 <= regs[rd];
                            alu_op3 <= '0;
                        end
                        default: begin
                            io_address <= reg_off;
                            io_data_out <= regs[rd];
                        end
                    endcase
                end
                operate: begin
                    // read data is valid while io_rd is low
                    if (cur_op == `OP_ALU_IOR)
                        alu_op2 <= io_data_in;
                    if (cur_op == `OP_IO && !io_rd)
                        regs[cur_rd] <= io_data_in;
                end
                writeback: begin
                    if (cur_op == `OP_ALU_RR || cur_op == `OP_ALU_IR)
                        regs[cur_rd] <= alu_out;
                    if (cur_op == `OP_ALU_RR && cur_wide)
                        regs[cur_rs] <= alu_out2;
                    if (cur_op == `OP_ALU_RIO)
                        io_data_out <= alu_out;
                end
                default: begin
                    if (cur_op == `OP_ALU_IOR)
                        regs[cur_rd] <= alu_out;
                end
            endcase
        end
    end

    // single-master bus, one strobe at a time and one cycle each
    a_strobe_excl: assert property (@(posedge clk) disable iff (!reset)
        !(!io_rd && !io_wr));
    a_wr_one_cycle: assert property (@(posedge clk) disable iff (!reset)
        !io_wr |=> io_wr);

endmodule

`default_nettype wire

/* design/io_bus_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module io_bus_bridge
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  io_rd,
    input  logic  io_wr,
    input  word_t io_address,
    input  word_t io_data_out,
    output word_t io_data_in,
    output logic  dev_rd,
    output logic  dev_wr,
    output word_t dev_address,
    output word_t dev_wdata,
    input  word_t dev_rdata
);

    localparam int RAM_AW = $clog2(`IO_LOCAL_WORDS);

    word_t ram [0:`IO_LOCAL_WORDS-1];
    logic is_ext, in_ram;

    assign is_ext = io_address >= `IO_EXT_BASE;
    assign in_ram = io_address < `IO_LOCAL_WORDS;

    // strobes reach the device bus only for external addresses
    assign dev_rd = io_rd | ~is_ext;
    assign dev_wr = io_wr | ~is_ext;
    assign dev_address = io_address;
    assign dev_wdata = io_data_out;

    always_ff @(posedge clk) begin
        if (!io_wr && in_ram)
            ram[io_address[RAM_AW-1:0]] <= io_data_out;
    end

    // holes between RAM and IO_EXT_BASE read as zero
    always_comb begin
        if (is_ext)
            io_data_in = dev_rdata;
        else if (in_ram)
            io_data_in = ram[io_address[RAM_AW-1:0]];
        else
            io_data_in = '0;
    end

    a_dev_wr_pulse: assert property (@(posedge clk) disable iff (!reset)
        !dev_wr |=> dev_wr);

endmodule

`default_nettype wire

/* design/program_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module program_mem (
    input  logic                        clk,
    input  logic [`PROG_ADDR_WIDTH-1:0] address,
    output logic [`INSTR_WIDTH-1:0]     instruction,
    input  logic                        load_en,
    input  logic [`PROG_ADDR_WIDTH-1:0] load_addr,
    input  logic [`INSTR_WIDTH-1:0]     load_data
);

    logic [`INSTR_WIDTH-1:0] mem [0:(1 << `PROG_ADDR_WIDTH)-1];

    // same-cycle read for the decode stage
    assign instruction = mem[address];

    always_ff @(posedge clk) begin
        if (load_en)
            mem[load_addr] <= load_data;
    end

endmodule

`default_nettype wire

/* testbench/clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
    parameter int PERIOD = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // power-on reset, active low
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module cpu_tb
    import cpu_pkg::*;
;

    localparam int HALT_LIMIT = 2000;
    // six tests, each with load, reset and run budget
    localparam int CYCLE_LIMIT = 6 * (HALT_LIMIT + 100) + 20;

    logic clk, por_reset, run_en, cpu_reset, interrupt, load_en;
    logic [`PROG_ADDR_WIDTH-1:0] load_addr;
    instr_t load_data;
    logic dev_rd, dev_wr, hlt, error;
    word_t dev_address, dev_wdata, dev_rdata;

    word_t dev_mem [0:15];
    word_t cap_addr [$];
    word_t cap_data [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t cap_rd [$];
    word_t exp_rd [$];
    instr_t prog [$];
    integer seed = 40100;
    int errors = 0;
    int cycle_count = 0;

    assign cpu_reset = por_reset & run_en;
    // device answers within the strobe cycle
    assign dev_rdata = dev_mem[dev_address[3:0]];

    clock_gen u_clock_gen (.clk(clk), .reset(por_reset));

    cpu_top u_cpu_top (
        .clk(clk), .reset(cpu_reset), .interrupt(interrupt),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .dev_rd(dev_rd), .dev_wr(dev_wr), .dev_address(dev_address),
        .dev_wdata(dev_wdata), .dev_rdata(dev_rdata), .hlt(hlt), .error(error)
    );

    // device bus monitor
    always @(posedge clk) begin
        if (!dev_wr) begin
            cap_addr.push_back(dev_address);
            cap_data.push_back(dev_wdata);
        end
        if (!dev_rd)
            cap_rd.push_back(dev_address);
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic instr_t mov_imm(input reg_id_t r, input word_t v);
        return {v, r, `OP_SPECIAL, 5'h1d};
    endfunction
    function automatic instr_t io_out(input reg_id_t rd, input reg_id_t rs, input reg_id_t off);
        return {off, rs, rd, `OP_IO, 5'd1};
    endfunction
    function automatic instr_t io_in(input reg_id_t rd, input reg_id_t rs, input reg_id_t off);
        return {off, rs, rd, `OP_IO, 5'd0};
    endfunction
    function automatic instr_t alu_reg(input alu_op_t f, input reg_id_t rd, input reg_id_t rs,
                                       input reg_id_t rt);
        return {rt, rs, rd, `OP_ALU_RR, f};
    endfunction
    function automatic instr_t alu_imm(input alu_op_t f, input reg_id_t rd, input word_t v);
        return {v, rd, `OP_ALU_IR, f};
    endfunction
    function automatic instr_t alu_from_io(input alu_op_t f, input reg_id_t rd,
                                           input reg_id_t rs, input reg_id_t rt);
        return {rt, rs, rd, `OP_ALU_IOR, f};
    endfunction
    function automatic instr_t alu_to_io(input alu_op_t f, input reg_id_t rd,
                                         input reg_id_t rs, input reg_id_t rt);
        return {rt, rs, rd, `OP_ALU_RIO, f};
    endfunction
    function automatic instr_t jump_if(input logic [3:0] cond, input word_t t);
        return {t, 8'h00, `OP_JMP, 1'b0, cond};
    endfunction
    function automatic instr_t call_to(input word_t t);
        return {t, 8'h00, `OP_CALL, 5'd0};
    endfunction
    function automatic instr_t special_op(input alu_op_t f);
        return {24'h0, `OP_SPECIAL, f};
    endfunction

    task automatic expect_write(input word_t a, input word_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    task automatic expect_read(input word_t a);
        exp_rd.push_back(a);
    endtask

    // reset held while the program is written
    task automatic load_program();
        @(posedge clk);
        run_en <= 1'b0;
        cap_addr.delete();
        cap_data.delete();
        cap_rd.delete();
        foreach (prog[i]) begin
            @(posedge clk);
            load_en <= 1'b1;
            load_addr <= i[`PROG_ADDR_WIDTH-1:0];
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        run_en <= 1'b1;
        prog.delete();
    endtask

    // with use_irq, raise interrupt at the first loop marker, drop it at the vector write
    task automatic run_to_halt(input string name, input logic exp_error, input logic use_irq);
        int cycles;
        int irq_state;
        cycles = 0;
        irq_state = 0;
        load_program();
        while (!hlt && cycles < HALT_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (use_irq && irq_state == 0 && !dev_wr && dev_address == 16'h8000) begin
                interrupt <= 1'b1;
                irq_state = 1;
            end else if (irq_state == 1 && !dev_wr && dev_address == 16'h8001) begin
                interrupt <= 1'b0;
                irq_state = 2;
            end
        end
        interrupt <= 1'b0;
        if (!hlt) begin
            $display("%s: cpu did not halt within %0d cycles", name, HALT_LIMIT);
            errors++;
        end
        if (error !== exp_error) begin
            $display("Mismatch %s: error expected %b actual %b", name, exp_error, error);
            errors++;
        end
    endtask

    task automatic check_writes(input string name);
        if (cap_addr.size() != exp_addr.size()) begin
            $display("Mismatch %s: write count expected %0d actual %0d", name,
                     exp_addr.size(), cap_addr.size());
            errors++;
        end
        foreach (exp_addr[i]) begin
            if (i < cap_addr.size()) begin
                if (cap_addr[i] !== exp_addr[i]) begin
                    $display("Mismatch %s: address %0d expected %h actual %h", name, i,
                             exp_addr[i], cap_addr[i]);
                    errors++;
                end
                if (cap_data[i] !== exp_data[i]) begin
                    $display("Mismatch %s: data %0d expected %h actual %h", name, i,
                             exp_data[i], cap_data[i]);
                    errors++;
                end
            end
        end
        foreach (cap_addr[i]) begin
            if (cap_addr[i] < `IO_EXT_BASE) begin
                $display("%s: device write strobe seen for local address %h", name, cap_addr[i]);
                errors++;
            end
        end
        exp_addr.delete();
        exp_data.delete();
    endtask

    // local reads must not strobe dev_rd
    task automatic check_reads(input string name);
        if (cap_rd.size() != exp_rd.size()) begin
            $display("Mismatch %s: read count expected %0d actual %0d", name,
                     exp_rd.size(), cap_rd.size());
            errors++;
        end
        foreach (exp_rd[i]) begin
            if (i < cap_rd.size() && cap_rd[i] !== exp_rd[i]) begin
                $display("Mismatch %s: read address %0d expected %h actual %h", name, i,
                         exp_rd[i], cap_rd[i]);
                errors++;
            end
        end
        exp_rd.delete();
    endtask

    task automatic test_move_out();
        word_t v0, v1;
        v0 = $random(seed);
        v1 = $random(seed);
        prog = '{mov_imm(1, 16'h8000), mov_imm(2, v0), mov_imm(3, v1),
                 io_out(2, 1, 3), io_out(3, 1, 7), special_op(5'h1f)};
        expect_write(16'h8003, v0);
        expect_write(16'h8007, v1);
        run_to_halt("move_out", 1'b0, 1'b0);
        check_writes("move_out");
        check_reads("move_out");
    endtask

    task automatic test_alu_forms();
        word_t a, b;
        logic [31:0] prod;
        a = $random(seed);
        b = $random(seed);
        b = b | 16'h1;
        prod = a * b;
        prog = '{mov_imm(1, 16'h8000), mov_imm(4, a), mov_imm(5, b),
                 mov_imm(10, 16'h8010), mov_imm(11, 16'h8011), mov_imm(12, 16'h8012),
                 alu_to_io(`ALU_OP_ADD, 5, 4, 10), alu_to_io(`ALU_OP_SUB, 5, 4, 11),
                 alu_to_io(`ALU_OP_XOR, 5, 4, 12),
                 mov_imm(6, 16'h0), mov_imm(7, a), alu_reg(`ALU_OP_MUL, 6, 7, 5),
                 io_out(6, 1, 8'h20), io_out(7, 1, 8'h21),
                 mov_imm(8, 16'h0), mov_imm(9, a), alu_reg(`ALU_OP_DIV, 8, 9, 5),
                 io_out(8, 1, 8'h22), io_out(9, 1, 8'h23), special_op(5'h1f)};
        expect_write(16'h8010, a + b);
        expect_write(16'h8011, a - b);
        expect_write(16'h8012, a ^ b);
        expect_write(16'h8020, prod[15:0]);
        expect_write(16'h8021, prod[31:16]);
        expect_write(16'h8022, a / b);
        expect_write(16'h8023, a % b);
        run_to_halt("alu_forms", 1'b0, 1'b0);
        check_writes("alu_forms");
        check_reads("alu_forms");
    endtask

    task automatic test_branches();
        word_t x, y;
        x = $random(seed);
        y = $random(seed);
        prog = '{mov_imm(1, 16'h8000), mov_imm(2, x), mov_imm(3, y),
                 mov_imm(5, 16'h00c1), mov_imm(6, 16'h00c0), alu_reg(`ALU_OP_CMP, 2, 2, 3),
                 jump_if(4'd1, 16'd9), io_out(6, 1, 0), jump_if(4'd0, 16'd10),
                 io_out(5, 1, 0), jump_if(4'd3, 16'd13), io_out(6, 1, 1),
                 jump_if(4'd0, 16'd14), io_out(5, 1, 1), alu_reg(`ALU_OP_CMP, 2, 2, 2),
                 jump_if(4'd6, 16'd18), io_out(6, 1, 2), special_op(5'h1f),
                 io_out(5, 1, 2), special_op(5'h1f)};
        // carry is the borrow of x - y, zero is x == y
        expect_write(16'h8000, (x < y) ? 16'h00c1 : 16'h00c0);
        expect_write(16'h8001, (x == y) ? 16'h00c1 : 16'h00c0);
        expect_write(16'h8002, 16'h00c1);
        run_to_halt("branches", 1'b0, 1'b0);
        check_writes("branches");
        check_reads("branches");
    endtask

    task automatic test_call_return();
        prog = '{mov_imm(1, 16'h8000), mov_imm(2, 16'h00a1), mov_imm(3, 16'h00a2),
                 mov_imm(4, 16'h00a3), mov_imm(5, 16'h00b0), call_to(16'd8),
                 io_out(5, 1, 7), special_op(5'h1f),
                 io_out(2, 1, 1), call_to(16'd12), io_out(2, 1, 6), special_op(5'h00),
                 io_out(3, 1, 2), call_to(16'd16), io_out(3, 1, 5), special_op(5'h00),
                 io_out(4, 1, 3), special_op(5'h00)};
        expect_write(16'h8001, 16'h00a1);
        expect_write(16'h8002, 16'h00a2);
        expect_write(16'h8003, 16'h00a3);
        expect_write(16'h8005, 16'h00a2);
        expect_write(16'h8006, 16'h00a1);
        expect_write(16'h8007, 16'h00b0);
        run_to_halt("call_return", 1'b0, 1'b0);
        check_writes("call_return");
        check_reads("call_return");
    endtask

    task automatic test_local_ram();
        word_t a, b;
        a = $random(seed);
        b = $random(seed);
        prog = '{mov_imm(1, 16'h8000), mov_imm(2, 16'h0), mov_imm(3, a), mov_imm(4, b),
                 io_out(3, 2, 5), io_out(4, 2, 6), io_in(5, 2, 5), io_in(6, 2, 6),
                 alu_reg(`ALU_OP_ADD, 7, 5, 6), io_out(7, 1, 8'h10),
                 mov_imm(8, 16'h8005), alu_from_io(`ALU_OP_ADD, 9, 7, 8),
                 io_out(9, 1, 8'h11), io_out(5, 1, 8'h12), special_op(5'h1f)};
        expect_write(16'h8010, a + b);
        expect_write(16'h8011, a + b + dev_mem[5]);
        expect_write(16'h8012, a);
        expect_read(16'h8005);
        run_to_halt("local_ram", 1'b0, 1'b0);
        check_writes("local_ram");
        check_reads("local_ram");
    endtask

    task automatic test_interrupt_error();
        int loops;
        int vectors;
        int vec_pos;
        loops = 0;
        vectors = 0;
        vec_pos = -1;
        prog = '{jump_if(4'd0, 16'd4), io_out(3, 1, 1), special_op(5'h10), special_op(5'h1f),
                 mov_imm(1, 16'h8000), mov_imm(2, 16'h1111), mov_imm(3, 16'h2222),
                 mov_imm(4, 16'h0), io_out(2, 1, 0), alu_imm(`ALU_OP_ADD, 4, 16'd1),
                 alu_imm(`ALU_OP_CMP, 4, 16'd6), jump_if(4'd4, 16'd8),
                 {24'h0, `OP_IO, 5'd5}};
        run_to_halt("interrupt_error", 1'b1, 1'b1);
        foreach (cap_addr[i]) begin
            if (cap_addr[i] == 16'h8000 && cap_data[i] == 16'h1111) begin
                loops++;
            end else if (cap_addr[i] == 16'h8001 && cap_data[i] == 16'h2222) begin
                vectors++;
                vec_pos = i;
            end else begin
                $display("interrupt_error: unexpected write %h to %h", cap_data[i], cap_addr[i]);
                errors++;
            end
        end
        if (loops != 6) begin
            $display("Mismatch interrupt_error: loop writes expected 6 actual %0d", loops);
            errors++;
        end
        if (vectors != 1) begin
            $display("Mismatch interrupt_error: vector writes expected 1 actual %0d", vectors);
            errors++;
        end
        if (vec_pos < 1 || vec_pos >= cap_addr.size() - 1) begin
            $display("interrupt_error: vector write did not land inside the loop");
            errors++;
        end
        check_reads("interrupt_error");
    endtask

    initial begin
        interrupt = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        run_en = 1'b0;
        for (int i = 0; i < 16; i++)
            dev_mem[i] = $random(seed);
        @(posedge por_reset);
        test_move_out();
        test_alu_forms();
        test_branches();
        test_call_return();
        test_local_ram();
        test_interrupt_error();
        $display("errors: %0d, cycles: %0d", errors, cycle_count);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
